//--- logic/tmds_pkg.sv
// Shared video and TMDS types, AXI4-Lite channel structs, register map, tokens, responses
`default_nettype none

package tmds_pkg;

    // ------------------------------------------------------------------
    // Video payload
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;    // Low byte, as in PIXEL
    } rgb_t;

    typedef struct packed {
        logic [3:0] ctl;     // CONTROL[7:4]
        logic       de;      // CONTROL[2]
        logic       vsync;   // CONTROL[1]
        logic       hsync;   // CONTROL[0]
    } video_ctrl_t;

    typedef struct packed {
        video_ctrl_t ctrl;
        rgb_t        pixel;
    } video_beat_t;

    typedef logic [9:0] tmds_sym_t;

    typedef struct packed {
        tmds_sym_t red;
        tmds_sym_t green;
        tmds_sym_t blue;     // Bits 9:0 of ENCODED
    } tmds_word_t;

    typedef logic signed [4:0] disp_t;

    // ------------------------------------------------------------------
    // AXI4-Lite request channels
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        valid;
    } axil_w_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axil_ar_t;

    // Register map, bits 5:2 decoded
    localparam logic [5:0] ADDR_PIXEL   = 6'h00;
    localparam logic [5:0] ADDR_CONTROL = 6'h04;
    localparam logic [5:0] ADDR_ENCODED = 6'h08;
    localparam logic [5:0] ADDR_STATUS  = 6'h0C;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Blanking tokens indexed by {c1, c0}
    localparam tmds_sym_t CTRL_TOKEN_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_TOKEN_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_TOKEN_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_TOKEN_11 = 10'b1010101011;

    localparam int BEAT_CNT_W = 16;

endpackage

`default_nettype wire

//--- logic/axil_regs.sv
// AXI4-Lite slave: register file, write and read channel control, video beat issue
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire tmds_pkg::axil_aw_t   aw,
    output logic                      awready,
    input  wire tmds_pkg::axil_w_t    w,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire tmds_pkg::axil_ar_t   ar,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire                       rready,
    input  wire tmds_pkg::tmds_word_t tmds_data,
    input  wire                       tmds_valid,
    output tmds_pkg::video_beat_t     beat,
    output logic                      beat_valid
);

    // Register file
    tmds_pkg::video_ctrl_t           ctrl_q;
    tmds_pkg::rgb_t                  pixel_q;
    tmds_pkg::tmds_word_t            encoded_q;
    logic [tmds_pkg::BEAT_CNT_W-1:0] beat_cnt;

    // Write channel state
    logic           aw_got;      // Address held, waiting for data
    logic           w_got;       // Data held, waiting for address
    logic [3:0]     aw_addr_q;
    logic [31:0]    w_data_q;
    logic [3:0]     w_strb_q;
    logic           aw_hs;
    logic           w_hs;
    logic           wr_fire;
    logic [3:0]     wr_addr;
    logic [31:0]    wr_data;
    logic [3:0]     wr_strb;
    logic           wr_pixel;
    logic           wr_control;
    tmds_pkg::rgb_t pixel_next;

    // Read channel
    logic           ar_hs;
    logic [31:0]    rd_data;
    logic [1:0]     rd_resp;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    always_comb begin
        aw_hs   = aw.valid && awready;
        w_hs    = w.valid && wready;
        wr_fire = (aw_hs || aw_got) && (w_hs || w_got);  // Both halves in hand
        wr_addr = aw_hs ? aw.addr[5:2] : aw_addr_q;
        wr_data = w_hs ? w.data : w_data_q;
        wr_strb = w_hs ? w.strb : w_strb_q;
        wr_pixel   = (wr_addr == tmds_pkg::ADDR_PIXEL[5:2]);
        wr_control = (wr_addr == tmds_pkg::ADDR_CONTROL[5:2]);

        // Strobed bytes merge into the held pixel
        pixel_next = pixel_q;
        for (int i = 0; i < 3; i++) begin
            if (wr_strb[i]) begin
                pixel_next[8*i +: 8] = wr_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            bvalid     <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            awready    <= aw.valid && !awready && !aw_got && !bvalid;
            wready     <= w.valid && !wready && !w_got && !bvalid;
            beat_valid <= wr_fire && wr_pixel;

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (aw_hs) aw_got <= 1'b1;
                if (w_hs)  w_got  <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            aw_addr_q <= aw.addr[5:2];
        end
        if (w_hs) begin
            w_data_q <= w.data;
            w_strb_q <= w.strb;
        end
        if (wr_fire) begin
            bresp <= (wr_pixel || wr_control) ? tmds_pkg::RESP_OKAY : tmds_pkg::RESP_SLVERR;
        end
        if (wr_fire && wr_pixel) begin
            beat <= '{ctrl: ctrl_q, pixel: pixel_next};
        end
    end

    // Register file updates, both from the bus and from the encoder
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl_q    <= '0;
            pixel_q   <= '0;
            encoded_q <= '0;
            beat_cnt  <= '0;
        end else begin
            if (wr_fire && wr_pixel) begin
                pixel_q <= pixel_next;
            end
            if (wr_fire && wr_control && wr_strb[0]) begin
                ctrl_q <= '{ctl: wr_data[7:4], de: wr_data[2],
                            vsync: wr_data[1], hsync: wr_data[0]};
            end
            if (tmds_valid) begin
                encoded_q <= tmds_data;
                beat_cnt  <= beat_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------
    always_comb begin
        ar_hs   = ar.valid && arready;
        rd_resp = tmds_pkg::RESP_OKAY;
        case (ar.addr[5:2])
            tmds_pkg::ADDR_PIXEL[5:2]:   rd_data = {8'h00, pixel_q};
            tmds_pkg::ADDR_CONTROL[5:2]: rd_data = {24'h0, ctrl_q.ctl, 1'b0, ctrl_q.de,
                                                    ctrl_q.vsync, ctrl_q.hsync};
            tmds_pkg::ADDR_ENCODED[5:2]: rd_data = {2'b00, encoded_q};
            tmds_pkg::ADDR_STATUS[5:2]:  rd_data = 32'(beat_cnt);
            default: begin
                rd_data = '0;
                rd_resp = tmds_pkg::RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ar.valid && !arready && !rvalid;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin                // Held stable while rvalid waits
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

//--- logic/tmds_channel_encoder.sv
// Single-channel TMDS 8b/10b encoder, two pipeline stages, running disparity
`timescale 1ns/1ps
`default_nettype none

module tmds_channel_encoder (
    input  wire                 aclk,
    input  wire                 aresetn,
    input  wire                 valid_in,
    input  wire                 de,
    input  wire [1:0]           ctrl,      // {c1, c0}
    input  wire [7:0]           data,
    output logic                valid_out,
    output tmds_pkg::tmds_sym_t sym
);

    // Stage 1 signals
    logic       [3:0] data_ones;
    logic             use_xnor;
    logic       [8:0] q_m;
    logic       [3:0] q_m_ones;
    logic             s1_valid;
    logic             s1_de;
    logic       [1:0] s1_ctrl;
    logic       [8:0] s1_q_m;
    logic       [3:0] s1_ones;

    // Stage 2 signals
    tmds_pkg::disp_t     disp;
    tmds_pkg::disp_t     diff;        // Ones minus zeros of q_m[7:0]
    tmds_pkg::disp_t     disp_next;
    tmds_pkg::tmds_sym_t sym_next;

    // ------------------------------------------------------------------
    // Stage 1: transition minimizing
    // ------------------------------------------------------------------
    always_comb begin
        data_ones = '0;
        for (int i = 0; i < 8; i++) begin
            data_ones = data_ones + 4'(data[i]);
        end
        use_xnor = (data_ones > 4'd4) || (data_ones == 4'd4 && !data[0]);

        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;

        q_m_ones = '0;
        for (int i = 0; i < 8; i++) begin
            q_m_ones = q_m_ones + 4'(q_m[i]);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_in;
        end
    end

    always_ff @(posedge aclk) begin
        s1_de   <= de;
        s1_ctrl <= ctrl;
        s1_q_m  <= q_m;
        s1_ones <= q_m_ones;
    end

    // ------------------------------------------------------------------
    // Stage 2: DC balance
    // ------------------------------------------------------------------
    always_comb begin
        diff = tmds_pkg::disp_t'(s1_ones) - tmds_pkg::disp_t'(4'd8 - s1_ones);
        if (!s1_de) begin
            disp_next = '0;             // Blanking resets the balance
            case (s1_ctrl)
                2'b00:   sym_next = tmds_pkg::CTRL_TOKEN_00;
                2'b01:   sym_next = tmds_pkg::CTRL_TOKEN_01;
                2'b10:   sym_next = tmds_pkg::CTRL_TOKEN_10;
                default: sym_next = tmds_pkg::CTRL_TOKEN_11;
            endcase
        end else if (disp == 0 || s1_ones == 4'd4) begin
            // Neutral case, bit 8 decides the inversion
            sym_next  = {~s1_q_m[8], s1_q_m[8], s1_q_m[8] ? s1_q_m[7:0] : ~s1_q_m[7:0]};
            disp_next = s1_q_m[8] ? disp + diff : disp - diff;
        end else if ((!disp[4] && s1_ones > 4'd4) || (disp[4] && s1_ones < 4'd4)) begin
            sym_next  = {1'b1, s1_q_m[8], ~s1_q_m[7:0]};   // Pull back toward zero
            disp_next = disp - diff + (s1_q_m[8] ? 5'sd2 : 5'sd0);
        end else begin
            sym_next  = {1'b0, s1_q_m[8], s1_q_m[7:0]};
            disp_next = disp + diff - (s1_q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_out <= 1'b0;
            disp      <= '0;
        end else begin
            valid_out <= s1_valid;
            if (s1_valid) begin
                disp <= disp_next;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_valid) begin
            sym <= sym_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/tmds_encoder.sv
// Three-channel TMDS encoder with control bit mapping and aligned output register
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire tmds_pkg::video_beat_t  beat,
    input  wire                         beat_valid,
    output tmds_pkg::tmds_word_t        tmds_data,
    output logic                        tmds_valid
);

    tmds_pkg::tmds_sym_t sym_red;
    tmds_pkg::tmds_sym_t sym_green;
    tmds_pkg::tmds_sym_t sym_blue;
    logic [2:0]          ch_valid;      // {red, green, blue}

    // Blue carries the syncs
    tmds_channel_encoder blue_enc (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .valid_in  (beat_valid),
        .de        (beat.ctrl.de),
        .ctrl      ({beat.ctrl.vsync, beat.ctrl.hsync}),
        .data      (beat.pixel.blue),
        .valid_out (ch_valid[0]),
        .sym       (sym_blue)
    );

    tmds_channel_encoder green_enc (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .valid_in  (beat_valid),
        .de        (beat.ctrl.de),
        .ctrl      (beat.ctrl.ctl[1:0]),
        .data      (beat.pixel.green),
        .valid_out (ch_valid[1]),
        .sym       (sym_green)
    );

    tmds_channel_encoder red_enc (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .valid_in  (beat_valid),
        .de        (beat.ctrl.de),
        .ctrl      (beat.ctrl.ctl[3:2]),
        .data      (beat.pixel.red),
        .valid_out (ch_valid[2]),
        .sym       (sym_red)
    );

    // ------------------------------------------------------------------
    // Output register, word leaves with all three symbols together
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tmds_valid <= 1'b0;
        end else begin
            tmds_valid <= &ch_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (&ch_valid) begin
            tmds_data <= '{red: sym_red, green: sym_green, blue: sym_blue};
        end
    end

endmodule

`default_nettype wire

//--- logic/tmds_encoder_axi.sv
// Top level: AXI4-Lite register block driving the three-channel TMDS encoder
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder_axi (
    input  wire                       aclk,
    input  wire                       aresetn,

    // AXI4-Lite slave
    input  wire tmds_pkg::axil_aw_t   s_axi_aw,
    output logic                      s_axi_awready,
    input  wire tmds_pkg::axil_w_t    s_axi_w,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  wire                       s_axi_bready,
    input  wire tmds_pkg::axil_ar_t   s_axi_ar,
    output logic                      s_axi_arready,
    output logic [31:0]               s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  wire                       s_axi_rready,

    // Encoded symbols
    output tmds_pkg::tmds_word_t      tmds_data,
    output logic                      tmds_valid
);

    tmds_pkg::video_beat_t beat;
    logic                  beat_valid;

    axil_regs axil_regs_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .aw         (s_axi_aw),
        .awready    (s_axi_awready),
        .w          (s_axi_w),
        .wready     (s_axi_wready),
        .bresp      (s_axi_bresp),
        .bvalid     (s_axi_bvalid),
        .bready     (s_axi_bready),
        .ar         (s_axi_ar),
        .arready    (s_axi_arready),
        .rdata      (s_axi_rdata),
        .rresp      (s_axi_rresp),
        .rvalid     (s_axi_rvalid),
        .rready     (s_axi_rready),
        .tmds_data  (tmds_data),    // Fed back for ENCODED and STATUS
        .tmds_valid (tmds_valid),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    tmds_encoder tmds_encoder_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .beat       (beat),
        .beat_valid (beat_valid),
        .tmds_data  (tmds_data),
        .tmds_valid (tmds_valid)
    );

endmodule

`default_nettype wire

//--- bench/tmds_ref_model.svh
// Reference DVI TMDS model: 8b/10b symbol encoding with per-channel running disparity
`ifndef TMDS_REF_MODEL_SVH
`define TMDS_REF_MODEL_SVH

int model_cnt [3];      // Running disparity per channel, 0 blue, 1 green, 2 red

function automatic logic [9:0] model_symbol(input int ch, input logic de,
                                            input logic [1:0] c, input logic [7:0] d);
    logic [8:0] q_m;
    logic [9:0] q_out;
    int         n1d;
    int         n1;
    int         n0;
    if (!de) begin
        model_cnt[ch] = 0;          // Blanking restarts the balance
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    end
    n1d    = $countones(d);
    q_m[0] = d[0];
    if (n1d > 4 || (n1d == 4 && d[0] == 1'b0)) begin
        for (int i = 1; i < 8; i++) q_m[i] = q_m[i-1] ~^ d[i];
        q_m[8] = 1'b0;
    end else begin
        for (int i = 1; i < 8; i++) q_m[i] = q_m[i-1] ^ d[i];
        q_m[8] = 1'b1;
    end
    n1 = $countones(q_m[7:0]);
    n0 = 8 - n1;
    if (model_cnt[ch] == 0 || n1 == n0) begin
        q_out = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
        model_cnt[ch] += q_m[8] ? (n1 - n0) : (n0 - n1);
    end else if ((model_cnt[ch] > 0 && n1 > n0) || (model_cnt[ch] < 0 && n0 > n1)) begin
        q_out = {1'b1, q_m[8], ~q_m[7:0]};
        model_cnt[ch] += (q_m[8] ? 2 : 0) + (n0 - n1);
    end else begin
        q_out = {1'b0, q_m[8], q_m[7:0]};
        model_cnt[ch] += (n1 - n0) - (q_m[8] ? 0 : 2);
    end
    return q_out;
endfunction

// ctrl is {ctl[3:0], de, vsync, hsync}, result is {red, green, blue}
function automatic logic [29:0] model_word(input logic [6:0] ctrl, input logic [23:0] pix);
    logic [9:0] blue;
    logic [9:0] green;
    logic [9:0] red;
    blue  = model_symbol(0, ctrl[2], ctrl[1:0], pix[7:0]);
    green = model_symbol(1, ctrl[2], ctrl[4:3], pix[15:8]);
    red   = model_symbol(2, ctrl[2], ctrl[6:5], pix[23:16]);
    return {red, green, blue};
endfunction

`endif

//--- bench/tb_tmds_encoder_axi.sv
// AXI4-Lite TMDS encoder testbench with clock, reset, bus tasks, stimulus table and checks
`timescale 1ns/1ps
`default_nettype none

module tb_tmds_encoder_axi;

    localparam int RESET_CYCLES   = 8;
    localparam int NUM_ENTRIES    = 30;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20 + RESET_CYCLES;
    localparam int LATENCY        = 4;      // Last write handshake to tmds_valid
    localparam bit OP_WR          = 1'b1;
    localparam bit OP_RD          = 1'b0;
    localparam logic [1:0] OK     = tmds_pkg::RESP_OKAY;
    localparam logic [1:0] ERR    = tmds_pkg::RESP_SLVERR;

    typedef struct packed {
        logic        op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic        rnd;       // Data replaced by a random word
        logic [3:0]  stall;     // Response delay in cycles, random when 0
    } entry_t;

    localparam entry_t STIMULUS [NUM_ENTRIES] = '{
        // Blanking, every sync pair and several ctl values
        '{OP_WR, 8'h04, 32'h0000_0000, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0012_3456, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h04, 32'h0000_0051, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h00AA_BBCC, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h04, 32'h0000_00A2, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h04, 32'h0000_00F3, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h00FF_FFFF, 4'hf, OK,  1'b0, 4'd0},
        // Active run
        '{OP_WR, 8'h04, 32'h0000_0004, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h00FF_FFFF, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0010_1010, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'hf, OK,  1'b1, 4'd0},
        // One blanking beat, then a second active run
        '{OP_WR, 8'h04, 32'h0000_0061, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'hf, OK,  1'b1, 4'd0},
        '{OP_WR, 8'h04, 32'h0000_0004, 4'hf, OK,  1'b0, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'hf, OK,  1'b1, 4'd0},
        '{OP_WR, 8'h00, 32'h0000_0000, 4'h5, OK,  1'b1, 4'd0},
        // Partial strobes and readback
        '{OP_WR, 8'h04, 32'h0000_00FF, 4'he, OK,  1'b0, 4'd0},
        '{OP_RD, 8'h04, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd0},
        '{OP_RD, 8'h00, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd0},
        // Error responses and back-pressure
        '{OP_WR, 8'h08, 32'hFFFF_FFFF, 4'hf, ERR, 1'b0, 4'd5},
        '{OP_WR, 8'h0C, 32'h0000_1234, 4'hf, ERR, 1'b0, 4'd0},
        '{OP_WR, 8'h20, 32'h0000_00F7, 4'hf, ERR, 1'b0, 4'd0},
        '{OP_RD, 8'h04, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd0},   // Unchanged by the above
        '{OP_RD, 8'h00, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd0},
        '{OP_RD, 8'h3C, 32'h0000_0000, 4'h0, ERR, 1'b0, 4'd4},
        '{OP_RD, 8'h08, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd6},
        '{OP_RD, 8'h0C, 32'h0000_0000, 4'h0, OK,  1'b0, 4'd0},
        '{OP_RD, 8'h10, 32'h0000_0000, 4'h0, ERR, 1'b0, 4'd0}
    };

    logic                 aclk;
    logic                 aresetn;
    tmds_pkg::axil_aw_t   aw;
    tmds_pkg::axil_w_t    w;
    tmds_pkg::axil_ar_t   ar;
    logic                 bready;
    logic                 rready;
    logic                 awready;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 arready;
    logic [31:0]          rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    tmds_pkg::tmds_word_t tmds_data;
    logic                 tmds_valid;

    int unsigned cycle = 0;
    int          errors;
    int          checks;
    int          pixel_writes;
    int          beats_seen;
    logic [6:0]  shadow_ctrl;           // {ctl, de, vsync, hsync}
    logic [23:0] shadow_pixel;
    logic [29:0] last_word;
    logic [29:0] exp_words [$];
    int unsigned exp_cycles [$];

    `include "tmds_ref_model.svh"

    tmds_encoder_axi tmds_encoder_axi_inst (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axi_aw      (aw),
        .s_axi_awready (awready),
        .s_axi_w       (w),
        .s_axi_wready  (wready),
        .s_axi_bresp   (bresp),
        .s_axi_bvalid  (bvalid),
        .s_axi_bready  (bready),
        .s_axi_ar      (ar),
        .s_axi_arready (arready),
        .s_axi_rdata   (rdata),
        .s_axi_rresp   (rresp),
        .s_axi_rvalid  (rvalid),
        .s_axi_rready  (rready),
        .tmds_data     (tmds_data),
        .tmds_valid    (tmds_valid)
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
        end
    endtask

    // ----------------------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------------------
    always @(negedge aclk) begin : monitor
        if (aresetn && tmds_valid) begin
            if (exp_words.size() == 0) begin
                errors++;
                $display("tmds_valid at cycle %0d without a pending pixel write", cycle);
            end else begin
                compare_value("tmds_data", {2'b00, tmds_data}, {2'b00, exp_words.pop_front()});
                compare_value("tmds_valid cycle", cycle, exp_cycles.pop_front());
            end
            last_word = tmds_data;
            beats_seen++;
        end
    end

    // ----------------------------------------------------------------------
    // Bus tasks entered and left on a falling edge
    // ----------------------------------------------------------------------
    task automatic drive_write(input logic [7:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input bit w_first,
                               output int unsigned done_cyc);
        bit aw_done;
        bit w_done;
        int n;
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        aw.addr = {24'h0, addr};
        w.data  = data;
        w.strb  = strb;
        if (w_first) w.valid = 1'b1;
        else aw.valid = 1'b1;
        while (!(aw_done && w_done)) begin
            if (aw.valid && awready) aw_done = 1'b1;   // Handshake on next rising edge
            if (w.valid && wready) w_done = 1'b1;
            done_cyc = cycle;
            @(negedge aclk);
            if (aw_done) compare_value("awready", 32'(awready), 32'd0);
            if (w_done) compare_value("wready", 32'(wready), 32'd0);
            if (aw_done) aw.valid = 1'b0;
            if (w_done) w.valid = 1'b0;
            if (n == 0 && w_first) aw.valid = 1'b1;   // Second channel one cycle later
            if (n == 0 && !w_first) w.valid = 1'b1;
            n++;
        end
    endtask

    task automatic take_write_response(input int stall, output logic [1:0] resp);
        while (!bvalid) @(negedge aclk);
        resp = bresp;
        repeat (stall) begin
            @(negedge aclk);
            compare_value("bvalid", 32'(bvalid), 32'd1);
            compare_value("bresp", 32'(bresp), 32'(resp));
        end
        bready = 1'b1;
        @(negedge aclk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        while (beats_seen != pixel_writes) @(negedge aclk);    // Let ENCODED settle
        @(negedge aclk);
        ar.addr  = {24'h0, addr};
        ar.valid = 1'b1;
        while (!arready) @(negedge aclk);
        @(negedge aclk);
        ar.valid = 1'b0;
        compare_value("arready", 32'(arready), 32'd0);
        while (!rvalid) @(negedge aclk);
        data = rdata;
        resp = rresp;
        repeat (stall) begin
            @(negedge aclk);
            compare_value("rvalid", 32'(rvalid), 32'd1);
            compare_value("rdata", rdata, data);
            compare_value("rresp", 32'(rresp), 32'(resp));
        end
        rready = 1'b1;
        @(negedge aclk);
        rready = 0;
    endtask

    function automatic void update_shadow(input logic [7:0] addr, input logic [31:0] data,
                                          input logic [3:0] strb, input int unsigned done_cyc);
        if (addr[5:2] == 4'h1 && strb[0]) begin
            shadow_ctrl = {data[7:4], data[2:0]};
        end
        if (addr[5:2] == 4'h0) begin
            for (int b = 0; b < 3; b++) begin
                if (strb[b]) shadow_pixel[8*b +: 8] = data[8*b +: 8];
            end
            pixel_writes++;
            exp_words.push_back(model_word(shadow_ctrl, shadow_pixel));
            exp_cycles.push_back(done_cyc + LATENCY);
        end
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        case (addr[5:2])
            4'h0:    return {8'h00, shadow_pixel};
            4'h1:    return {24'h0, shadow_ctrl[6:3], 1'b0, shadow_ctrl[2:0]};
            4'h2:    return {2'b00, last_word};
            4'h3:    return 32'(pixel_writes);
            default: return 32'h0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin : main
        entry_t      ent;
        logic [31:0] data;
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        int          stall;
        int unsigned done_cyc;
        bit          w_first;
        int unsigned seed_draw;
        aclk         = 1'b0;
        aresetn      = 1'b0;
        aw           = '0;
        w            = '0;
        ar           = '0;
        bready       = 1'b0;
        rready       = 1'b0;
        shadow_ctrl  = '0;
        shadow_pixel = '0;
        last_word    = '0;
        w_first      = 1'b0;
        seed_draw    = $urandom(32'hd412c5ef);

        repeat (RESET_CYCLES) @(negedge aclk);
        compare_value("awready", 32'(awready), 32'd0);
        compare_value("wready", 32'(wready), 32'd0);
        compare_value("arready", 32'(arready), 32'd0);
        compare_value("bvalid", 32'(bvalid), 32'd0);
        compare_value("rvalid", 32'(rvalid), 32'd0);
        compare_value("tmds_valid", 32'(tmds_valid), 32'd0);
        aresetn = 1'b1;
        @(negedge aclk);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ent   = STIMULUS[i];
            data  = ent.rnd ? $urandom : ent.data;
            stall = (ent.stall != 0) ? int'(ent.stall) : int'($urandom_range(3, 0));
            if (ent.op == OP_WR) begin
                drive_write(ent.addr, data, ent.strb, w_first, done_cyc);
                w_first = !w_first;
                update_shadow(ent.addr, data, ent.strb, done_cyc);
                take_write_response(stall, got_resp);
                compare_value("bresp", 32'(got_resp), 32'(ent.resp));
            end else begin
                axi_read(ent.addr, stall, got_data, got_resp);
                compare_value("rresp", 32'(got_resp), 32'(ent.resp));
                compare_value("rdata", got_data, expected_read(ent.addr));
            end
        end
        while (beats_seen != pixel_writes) @(negedge aclk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tmds_encoder_axi.f
+incdir+bench
logic/tmds_pkg.sv
logic/axil_regs.sv
logic/tmds_channel_encoder.sv
logic/tmds_encoder.sv
logic/tmds_encoder_axi.sv
bench/tb_tmds_encoder_axi.sv
